//--- ppu_timing_pkg.sv
// ################################################
// PPU frame timing: line and frame constants and
// the counter types shared by the video blocks
// ################################################
package ppu_timing_pkg;

  typedef logic [8:0] cycle_t;     // Pixel position within a line
  typedef logic [8:0] scanline_t;  // Line number, all ones is pre-render

  // Line end, 341 cycles on a normal line
  localparam logic [5:0] last_cycle_group = 6'd42;  // Cycles 336..343
  localparam logic [3:0] line_end_cycle   = 4'd4;   // 340, or 339 on the short line

  // Frame layout
  localparam scanline_t vblank_start_line = 9'd240;
  localparam scanline_t vblank_end_line   = 9'd260;
  localparam scanline_t pre_render_line   = 9'h1FF;

  // Scroll register events within a line
  localparam cycle_t sprite_fetch_start   = 9'd256;  // Horizontal reload window
  localparam cycle_t prefetch_start       = 9'd320;  // Next line's first two tiles
  localparam cycle_t prefetch_end         = 9'd336;
  localparam cycle_t prerender_copy_cycle = 9'd304;
  localparam cycle_t vert_incr_cycle      = 9'd251;

  localparam logic [4:0] coarse_y_wrap = 5'd29;  // Last tile row of a name table

endpackage

//--- ppu_bus_pkg.sv
// ################################################
// PPU bus view: CPU register map, VRAM address,
// scroll address, pixel and colour types
// ################################################
package ppu_bus_pkg;

  typedef logic [2:0]  cpu_addr_t;   // CPU register select
  typedef logic [7:0]  byte_t;
  typedef logic [14:0] loopy_t;      // Fine Y, name table, coarse Y, coarse X
  typedef logic [13:0] vram_addr_t;
  typedef logic [2:0]  fine_x_t;
  typedef logic [3:0]  bg_pixel_t;   // Attribute bits over pattern bits
  typedef logic [4:0]  pal_index_t;
  typedef logic [5:0]  color_t;

  // CPU visible registers
  localparam cpu_addr_t reg_ctrl   = 3'd0;
  localparam cpu_addr_t reg_mask   = 3'd1;
  localparam cpu_addr_t reg_status = 3'd2;
  localparam cpu_addr_t reg_scroll = 3'd5;
  localparam cpu_addr_t reg_addr   = 3'd6;
  localparam cpu_addr_t reg_data   = 3'd7;

  localparam logic [5:0] pal_page = 6'h3F;  // Address bits 13..8 of palette space

  // Data port address steps, picked by control bit 2
  localparam loopy_t incr_across = 15'd1;
  localparam loopy_t incr_down   = 15'd32;

endpackage

//--- ppu_frame_timer.sv
// ################################################
// Frame timer: cycle and scanline counters, vblank
// flag and pre-render line with odd-frame skip
// ################################################
`timescale 1ns/1ps

module ppu_frame_timer (
  input  logic                       clk,
  input  logic                       ce,
  input  logic                       reset,
  input  logic                       is_rendering,
  output ppu_timing_pkg::cycle_t     cycle,
  output ppu_timing_pkg::scanline_t  scanline,
  output logic                       in_vblank,
  output logic                       end_of_line,
  output logic                       last_group,
  output logic                       entering_vblank,
  output logic                       exiting_vblank,
  output logic                       pre_render
);

  logic       second_frame;  // Toggles each frame
  logic       short_line;    // Odd pre-render line loses one cycle
  logic [3:0] end_nibble;

  assign last_group  = (cycle[8:3] == ppu_timing_pkg::last_cycle_group);
  assign short_line  = pre_render && second_frame && is_rendering;
  assign end_nibble  = short_line ? ppu_timing_pkg::line_end_cycle - 4'd1
                                  : ppu_timing_pkg::line_end_cycle;
  assign end_of_line = last_group && (cycle[3:0] == end_nibble);

  // Flag edges land on the last cycle of lines 240 and 260
  assign entering_vblank = end_of_line && (scanline == ppu_timing_pkg::vblank_start_line);
  assign exiting_vblank  = end_of_line && (scanline == ppu_timing_pkg::vblank_end_line);

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle        <= '0;
      scanline     <= '0;
      in_vblank    <= 1'b1;
      pre_render   <= 1'b0;
      second_frame <= 1'b0;
    end else if (ce) begin
      cycle <= end_of_line ? '0 : cycle + 9'd1;
      if (entering_vblank)
        in_vblank <= 1'b1;
      else if (exiting_vblank)
        in_vblank <= 1'b0;
      // Line 260 wraps to the pre-render line, which then counts up to 0
      if (end_of_line) begin
        scanline   <= exiting_vblank ? ppu_timing_pkg::pre_render_line : scanline + 9'd1;
        pre_render <= exiting_vblank;
        if (exiting_vblank)
          second_frame <= !second_frame;
      end
    end
  end

endmodule

//--- ppu_scroll_regs.sv
// ################################################
// Scroll registers: current and temporary VRAM
// address, fine X, write toggle and render steps
// ################################################
`timescale 1ns/1ps

module ppu_scroll_regs (
  input  logic                    clk,
  input  logic                    ce,
  input  logic                    reset,
  input  logic                    is_rendering,
  input  logic                    pre_render,
  input  logic                    read,
  input  logic                    write,
  input  ppu_bus_pkg::cpu_addr_t  ain,
  input  ppu_bus_pkg::byte_t      din,
  input  ppu_timing_pkg::cycle_t  cycle,
  input  logic                    incr_sel,    // 1 steps the data port by 32
  output ppu_bus_pkg::loopy_t     loopy,
  output ppu_bus_pkg::fine_x_t    fine_x,
  output logic                    pal_select
);

  ppu_bus_pkg::loopy_t v_addr;  // Current address
  ppu_bus_pkg::loopy_t t_addr;  // Temporary address
  logic                toggle;  // Second write of scroll or address pair
  logic                coarse_x_step;

  // Step right after each attribute fetch, on visible and prefetch tiles
  assign coarse_x_step = (cycle[2:0] == 3'd3) &&
                         (cycle < ppu_timing_pkg::sprite_fetch_start ||
                          (cycle >= ppu_timing_pkg::prefetch_start &&
                           cycle < ppu_timing_pkg::prefetch_end));

  always_ff @(posedge clk) begin
    if (reset) begin
      v_addr <= '0;
      t_addr <= '0;
      fine_x <= '0;
      toggle <= 1'b0;
    end else if (ce) begin
      if (is_rendering) begin
        if (coarse_x_step) begin
          v_addr[4:0] <= v_addr[4:0] + 5'd1;
          v_addr[10]  <= v_addr[10] ^ (v_addr[4:0] == 5'd31);  // Next name table across
        end
        if (cycle == ppu_timing_pkg::vert_incr_cycle) begin
          v_addr[14:12] <= v_addr[14:12] + 3'd1;
          if (v_addr[14:12] == 3'd7) begin
            if (v_addr[9:5] == ppu_timing_pkg::coarse_y_wrap) begin
              v_addr[9:5] <= '0;
              v_addr[11]  <= !v_addr[11];
            end else begin
              v_addr[9:5] <= v_addr[9:5] + 5'd1;
            end
          end
        end
        if (cycle == ppu_timing_pkg::sprite_fetch_start)
          {v_addr[10], v_addr[4:0]} <= {t_addr[10], t_addr[4:0]};  // Horizontal copy
        if (cycle == ppu_timing_pkg::prerender_copy_cycle && pre_render)
          v_addr <= t_addr;
      end
      // CPU accesses override the render updates above
      if (write && ain == ppu_bus_pkg::reg_ctrl) begin
        t_addr[11:10] <= din[1:0];
      end else if (write && ain == ppu_bus_pkg::reg_scroll) begin
        if (!toggle) begin
          t_addr[4:0] <= din[7:3];
          fine_x      <= din[2:0];
        end else begin
          t_addr[9:5]   <= din[7:3];
          t_addr[14:12] <= din[2:0];
        end
        toggle <= !toggle;
      end else if (write && ain == ppu_bus_pkg::reg_addr) begin
        if (!toggle) begin
          t_addr[14:8] <= {1'b0, din[5:0]};  // High byte, bit 14 cleared
        end else begin
          t_addr[7:0] <= din;
          v_addr      <= {t_addr[14:8], din};
        end
        toggle <= !toggle;
      end else if (read && ain == ppu_bus_pkg::reg_status) begin
        toggle <= 1'b0;
      end else if ((read || write) && ain == ppu_bus_pkg::reg_data && !is_rendering) begin
        v_addr <= v_addr + (incr_sel ? ppu_bus_pkg::incr_down : ppu_bus_pkg::incr_across);
      end
    end
  end

  assign loopy      = v_addr;
  assign pal_select = (v_addr[13:8] == ppu_bus_pkg::pal_page);

endmodule

//--- ppu_bg_painter.sv
// ################################################
// Background painter: captures tile fetches and
// shifts out pixels offset by fine X
// ################################################
`timescale 1ns/1ps

module ppu_bg_painter (
  input  logic                    clk,
  input  logic                    ce,
  input  logic                    shift_en,
  input  ppu_timing_pkg::cycle_t  cycle,
  input  ppu_bus_pkg::fine_x_t    fine_x,
  input  ppu_bus_pkg::loopy_t     loopy,
  input  ppu_bus_pkg::byte_t      vram_din,
  output ppu_bus_pkg::byte_t      name_tile,
  output ppu_bus_pkg::bg_pixel_t  bg_pixel
);

  logic [15:0]        patt_lo_pipe;  // Pattern plane 0
  logic [15:0]        patt_hi_pipe;  // Pattern plane 1
  logic [8:0]         attr_lo_pipe;
  logic [8:0]         attr_hi_pipe;
  logic [1:0]         attr_bits;     // Quadrant of the attribute byte
  ppu_bus_pkg::byte_t patt_lo;       // Plane 0 byte from group cycle 5
  ppu_bus_pkg::byte_t lo_rev;
  ppu_bus_pkg::byte_t hi_rev;
  logic [3:0]         tap;

  // Leftmost pixel sits in bit 7, flip so it shifts out first
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      lo_rev[i] = patt_lo[7 - i];
      hi_rev[i] = vram_din[7 - i];  // Plane 1 arrives at group cycle 7
    end
  end

  always_ff @(posedge clk) begin
    if (ce) begin
      case (cycle[2:0])
        3'd1: name_tile <= vram_din;
        3'd3: attr_bits <= vram_din[{loopy[6], loopy[1], 1'b0} +: 2];  // Coarse Y/X bit 1
        3'd5: patt_lo   <= vram_din;
        default: ;
      endcase
      if (shift_en) begin
        patt_lo_pipe[14:0] <= patt_lo_pipe[15:1];
        patt_hi_pipe[14:0] <= patt_hi_pipe[15:1];
        attr_lo_pipe[7:0]  <= attr_lo_pipe[8:1];
        attr_hi_pipe[7:0]  <= attr_hi_pipe[8:1];
        if (cycle[2:0] == 3'd7) begin  // Refill the upper half with the next tile
          patt_lo_pipe[15:8] <= lo_rev;
          patt_hi_pipe[15:8] <= hi_rev;
          attr_lo_pipe[8]    <= attr_bits[0];
          attr_hi_pipe[8]    <= attr_bits[1];
        end
      end
    end
  end

  assign tap      = {1'b0, fine_x};
  assign bg_pixel = {attr_hi_pipe[tap], attr_lo_pipe[tap], patt_hi_pipe[tap], patt_lo_pipe[tap]};

endmodule

//--- ppu_palette_ram.sv
// ################################################
// Palette RAM: 32 colours, backdrop mirroring and
// grayscale on the output
// ################################################
`timescale 1ns/1ps

module ppu_palette_ram (
  input  logic                    clk,
  input  logic                    ce,
  input  logic                    is_rendering,
  input  logic                    pal_select,
  input  logic                    pal_write,
  input  logic                    grayscale,
  input  ppu_bus_pkg::bg_pixel_t  bg_pixel,
  input  ppu_bus_pkg::loopy_t     loopy,
  input  ppu_bus_pkg::byte_t      din,
  output ppu_bus_pkg::color_t     color
);

  ppu_bus_pkg::color_t     pal_mem [32];
  ppu_bus_pkg::pal_index_t raw_idx;
  ppu_bus_pkg::pal_index_t idx;      // After backdrop mirroring
  ppu_bus_pkg::color_t     entry;

  // Pixel index while painting, CPU address otherwise
  assign raw_idx = is_rendering ? {1'b0, bg_pixel}
                 : pal_select   ? loopy[4:0]
                 :                '0;

  assign idx   = (raw_idx[1:0] == 2'b00) ? '0 : raw_idx;  // Every colour 0 is the backdrop
  assign entry = pal_mem[idx];
  assign color = grayscale ? {entry[5:4], 4'b0000} : entry;

  always_ff @(posedge clk) begin
    // Mirrors at 4, 8, 12 and their upper copies do not store
    if (ce && pal_write && !(raw_idx[3:2] != 2'b00 && raw_idx[1:0] == 2'b00))
      pal_mem[idx] <= din[5:0];
  end

endmodule

//--- ppu_cpu_port.sv
// ################################################
// CPU port: control, mask and status registers,
// NMI, VRAM strobes and the buffered data read
// ################################################
`timescale 1ns/1ps

module ppu_cpu_port (
  input  logic                       clk,
  input  logic                       ce,
  input  logic                       reset,
  input  logic                       read,
  input  logic                       write,
  input  ppu_bus_pkg::cpu_addr_t     ain,
  input  ppu_bus_pkg::byte_t         din,
  input  ppu_bus_pkg::byte_t         vram_din,
  input  ppu_timing_pkg::cycle_t     cycle,
  input  ppu_timing_pkg::scanline_t  scanline,
  input  logic                       in_vblank,
  input  logic                       end_of_line,
  input  logic                       entering_vblank,
  input  logic                       exiting_vblank,
  input  logic                       pal_select,
  input  ppu_bus_pkg::color_t        color,
  output ppu_bus_pkg::byte_t         dout,
  output logic                       nmi,
  output logic                       is_rendering,
  output logic                       incr_sel,
  output logic                       bg_patt,
  output logic                       grayscale,
  output logic                       show_bg,
  output logic                       vram_r,
  output logic                       vram_w,
  output logic                       pal_write
);

  logic               vbl_enable;     // Control bit 7
  logic               bg_clip_off;    // Mask bit 1, show BG in the left column
  logic               bg_enable;      // Mask bit 3
  logic               vbl_occurred;
  logic               read_pending;   // Data port read issued last cycle
  ppu_bus_pkg::byte_t read_buf;
  logic               data_access;

  assign data_access = (ain == ppu_bus_pkg::reg_data);

  assign is_rendering = bg_enable && !in_vblank &&
                        (scanline != ppu_timing_pkg::vblank_start_line);
  assign show_bg      = bg_enable && (bg_clip_off || cycle[7:3] != 5'd0);
  assign nmi          = vbl_occurred && vbl_enable;

  // Fetch on every even cycle of a rendered line, plus CPU data reads
  assign vram_r    = (read && data_access) || (is_rendering && !cycle[0] && !end_of_line);
  assign vram_w    = write && data_access && !pal_select && !is_rendering;
  assign pal_write = write && data_access && pal_select;

  always_ff @(posedge clk) begin
    if (reset) begin
      vbl_enable   <= 1'b0;
      incr_sel     <= 1'b0;
      bg_patt      <= 1'b0;
      grayscale    <= 1'b0;
      bg_clip_off  <= 1'b0;
      bg_enable    <= 1'b0;
      vbl_occurred <= 1'b0;
      read_pending <= 1'b0;
    end else if (ce) begin
      if (write && ain == ppu_bus_pkg::reg_ctrl) begin
        incr_sel   <= din[2];
        bg_patt    <= din[4];
        vbl_enable <= din[7];
      end
      if (write && ain == ppu_bus_pkg::reg_mask) begin
        grayscale   <= din[0];
        bg_clip_off <= din[1];
        bg_enable   <= din[3];
      end
      if (exiting_vblank) vbl_occurred <= 1'b0;
      if (entering_vblank) vbl_occurred <= 1'b1;
      if (read && ain == ppu_bus_pkg::reg_status)
        vbl_occurred <= 1'b0;  // Status read acknowledges vblank
      read_pending <= read && data_access;
    end
  end

  // VRAM answers one cycle after the strobe
  always_ff @(posedge clk) begin
    if (ce && read_pending)
      read_buf <= vram_din;
  end

  always_comb begin
    if (ain == ppu_bus_pkg::reg_status)
      dout = {vbl_occurred, 7'b0000000};
    else if (data_access && pal_select)
      dout = {2'b00, color};  // Palette reads bypass the buffer
    else
      dout = read_buf;
  end

endmodule

//--- ppu_top.sv
// ################################################
// PPU background core: timer, CPU port, scroll,
// painter and palette, plus VRAM address mux
// ################################################
`timescale 1ns/1ps

module ppu_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       ce,
  input  logic                       read,
  input  logic                       write,
  input  ppu_bus_pkg::cpu_addr_t     ain,
  input  ppu_bus_pkg::byte_t         din,
  input  ppu_bus_pkg::byte_t         vram_din,
  output ppu_bus_pkg::byte_t         dout,
  output ppu_bus_pkg::byte_t         vram_dout,
  output logic                       nmi,
  output logic                       vram_r,
  output logic                       vram_w,
  output ppu_bus_pkg::vram_addr_t    vram_a,
  output ppu_bus_pkg::color_t        color,
  output ppu_timing_pkg::scanline_t  scanline,
  output ppu_timing_pkg::cycle_t     cycle
);

  logic in_vblank, end_of_line, last_group, entering_vblank, exiting_vblank, pre_render;
  logic is_rendering, incr_sel, bg_patt, grayscale, show_bg, pal_write, pal_select;
  ppu_bus_pkg::loopy_t    loopy;
  ppu_bus_pkg::fine_x_t   fine_x;
  ppu_bus_pkg::byte_t     name_tile;
  ppu_bus_pkg::bg_pixel_t bg_raw;
  ppu_bus_pkg::bg_pixel_t bg_pixel;  // Blanked pattern bits where BG is hidden

  ppu_frame_timer u_timer (.*);
  ppu_cpu_port    u_cpu   (.*);
  ppu_scroll_regs u_scroll (.*);
  ppu_bg_painter  u_bg (.clk, .ce, .shift_en(!last_group), .cycle, .fine_x, .loopy,
                        .vram_din, .name_tile, .bg_pixel(bg_raw));
  ppu_palette_ram u_pal (.*);

  assign bg_pixel  = {bg_raw[3:2], show_bg ? bg_raw[1:0] : 2'b00};
  assign vram_dout = din;

  // Group cycles 0-1 name, 2-3 attribute, 4-7 the two pattern planes
  assign vram_a = !is_rendering          ? loopy[13:0]
                : (cycle[2:1] == 2'd0)   ? {2'b10, loopy[11:0]}
                : (cycle[2:1] == 2'd1)   ? {2'b10, loopy[11:10], 4'b1111, loopy[9:7], loopy[4:2]}
                :                          {1'b0, bg_patt, name_tile, cycle[1], loopy[14:12]};

endmodule

//--- tb_ppu.sv
// ################################################
// PPU testbench: CPU register table, synchronous
// VRAM model and frame level background checks
// ################################################
`timescale 1ns/1ps

module tb_ppu;

  typedef enum {op_write, op_read, op_peek, op_wait_vbl, op_nmi, op_mem, op_color} op_t;

  logic                      clk, reset, ce, read, write, nmi, vram_r, vram_w;
  ppu_bus_pkg::cpu_addr_t    ain;
  ppu_bus_pkg::byte_t        din, dout, vram_dout;
  ppu_bus_pkg::byte_t        vram_din = '0;
  ppu_bus_pkg::vram_addr_t   vram_a;
  ppu_bus_pkg::color_t       color;
  ppu_timing_pkg::scanline_t scanline;
  ppu_timing_pkg::cycle_t    cycle;

  ppu_bus_pkg::byte_t      vram    [16384];  // Model contents
  ppu_bus_pkg::byte_t      ref_mem [16384];  // Expected contents
  ppu_bus_pkg::color_t     pal_ref [32];
  op_t                     op_kind [256];
  int                      op_grp  [256];
  ppu_bus_pkg::vram_addr_t op_addr [256];    // Register in the low bits, or model address
  ppu_bus_pkg::byte_t      op_data [256];
  ppu_bus_pkg::byte_t      op_exp  [256];
  int n_ops, cur_grp, n_checks, n_errors, cycle_count;
  int          cycle_limit = 2 * 341 * 262 + 16;  // Two frames and reset, ops add more
  logic [31:0] lcg_state = 32'd47;
  ppu_bus_pkg::vram_addr_t vref;                  // Expected scroll address
  ppu_bus_pkg::byte_t      buf_ref;               // Expected read buffer
  logic buf_valid = 1'b0;
  logic step_down = 1'b0;
  logic gray_ref  = 1'b0;

  ppu_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Synchronous VRAM, data one cycle after the strobe
  always @(posedge clk) begin
    if (vram_w) vram[vram_a] = vram_dout;
    if (vram_r) vram_din <= vram[vram_a];
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("run stopped after %0d cycles before the table finished", cycle_count);
        $display("Simulation failed");
        $finish;
      end
    end
  end

  function automatic ppu_bus_pkg::byte_t lcg_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic ppu_bus_pkg::byte_t fill_byte(input int a);
    return a[7:0] ^ {a[13:8], 2'b01};  // Every address bit shows up
  endfunction

  // Colour 0 of any sub-palette is the backdrop
  function automatic ppu_bus_pkg::byte_t pal_read_exp(input ppu_bus_pkg::vram_addr_t a);
    ppu_bus_pkg::color_t e;
    e = pal_ref[(a[1:0] == 2'b00) ? 5'd0 : a[4:0]];
    return gray_ref ? {2'b00, e[5:4], 4'h0} : {2'b00, e};
  endfunction

  task automatic put_op(input op_t k, input int a, input int d, input int e);
    op_kind[n_ops] = k;
    op_grp[n_ops]  = cur_grp;
    op_addr[n_ops] = ppu_bus_pkg::vram_addr_t'(a);
    op_data[n_ops] = ppu_bus_pkg::byte_t'(d);
    op_exp[n_ops]  = ppu_bus_pkg::byte_t'(e);
    n_ops++;
    cycle_limit += 4;
  endtask

  task automatic reg_write(input ppu_bus_pkg::cpu_addr_t a, input ppu_bus_pkg::byte_t d);
    put_op(op_write, a, d, 0);
    if (a == ppu_bus_pkg::reg_ctrl) step_down = d[2];
    if (a == ppu_bus_pkg::reg_mask) gray_ref = d[0];
  endtask

  task automatic set_addr(input ppu_bus_pkg::vram_addr_t a);
    reg_write(ppu_bus_pkg::reg_addr, {2'b00, a[13:8]});
    reg_write(ppu_bus_pkg::reg_addr, a[7:0]);
    vref = a;
  endtask

  task automatic data_write(input ppu_bus_pkg::byte_t d);
    reg_write(ppu_bus_pkg::reg_data, d);
    if (vref[13:8] != ppu_bus_pkg::pal_page)
      ref_mem[vref] = d;
    else if (vref[1:0] != 2'b00)
      pal_ref[vref[4:0]] = d[5:0];
    else if (vref[3:2] == 2'b00)
      pal_ref[0] = d[5:0];  // 3F00 and 3F10 hold the backdrop
    vref = vref + (step_down ? 14'd32 : 14'd1);
  endtask

  // First read after reset has no known buffer, so it is not compared
  task automatic data_read();
    if (vref[13:8] == ppu_bus_pkg::pal_page)
      put_op(op_read, ppu_bus_pkg::reg_data, 0, pal_read_exp(vref));
    else if (buf_valid)
      put_op(op_read, ppu_bus_pkg::reg_data, 0, buf_ref);
    else
      put_op(op_peek, ppu_bus_pkg::reg_data, 0, 0);
    buf_ref   = ref_mem[vref];
    buf_valid = 1'b1;
    vref      = vref + (step_down ? 14'd32 : 14'd1);
  endtask

  task automatic check_byte(input string name, input ppu_bus_pkg::byte_t got,
                            input ppu_bus_pkg::byte_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_color(input string name, input ppu_bus_pkg::color_t got,
                             input ppu_bus_pkg::color_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  task automatic check_line(input string name, input ppu_timing_pkg::scanline_t got,
                            input ppu_timing_pkg::scanline_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_cycle(input string name, input ppu_timing_pkg::cycle_t got,
                             input ppu_timing_pkg::cycle_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Both pattern planes all ones, every attribute quadrant 0
  task automatic load_solid_tiles();
    for (int a = 0; a < 'h2000; a++)
      vram[a] = 8'hFF;
    for (int a = 'h23C0; a < 'h2400; a++)
      for (int nt = 0; nt < 4; nt++)
        vram[a + nt * 'h400] = 8'h00;
  endtask

  // Starts and ends 10 ns after a rising edge
  task automatic run_op(input int i);
    case (op_kind[i])
      op_write, op_read, op_peek: begin
        ain   = op_addr[i][2:0];
        din   = op_data[i];
        write = (op_kind[i] == op_write);
        read  = !write;
        #40;
        if (op_kind[i] == op_read)
          check_byte("dout", dout, op_exp[i]);
        @(posedge clk);
        #10;
        write = 1'b0;
        read  = 1'b0;
        @(posedge clk);  // Idle cycle, buffer reload lands here
        #10;
      end
      op_wait_vbl: begin
        while (!nmi) begin
          @(posedge clk);
          #10;
        end
        check_line("scanline", scanline, 9'd241);
        check_cycle("cycle", cycle, 9'd0);  // First cycle after the wrap out of line 240
      end
      op_nmi: check_bit("nmi", nmi, op_exp[i][0]);
      op_mem: check_byte($sformatf("vram[%h]", op_addr[i]), vram[op_addr[i]], op_exp[i]);
      op_color: begin
        load_solid_tiles();
        while (scanline != 9'd10 || cycle != 9'd64) begin
          @(posedge clk);
          #10;
        end
        repeat (137) begin  // Cycles 64 to 200
          #40;
          check_color("color", color, op_exp[i][5:0]);
          @(posedge clk);
          #10;
        end
      end
      default: ;
    endcase
  endtask

  initial begin
    int err_mark;
    reset    = 1'b1;
    ce       = 1'b1;
    read     = 1'b0;
    write    = 1'b0;
    ain      = '0;
    din      = '0;
    n_ops    = 0;
    n_checks = 0;
    n_errors = 0;
    for (int a = 0; a < 16384; a++) begin
      vram[a]    = fill_byte(a);
      ref_mem[a] = fill_byte(a);
    end
    cur_grp = 1;  // Reset state
    put_op(op_read, ppu_bus_pkg::reg_status, 0, 8'h00);
    cur_grp = 2;  // Address port, both strides, toggle clear
    set_addr(14'h0500);
    for (int k = 0; k < 8; k++)
      data_write(lcg_byte());
    for (int k = 0; k < 8; k++)
      put_op(op_mem, 'h0500 + k, 0, ref_mem['h0500 + k]);
    reg_write(ppu_bus_pkg::reg_ctrl, 8'h04);
    set_addr(14'h0600);
    for (int k = 0; k < 4; k++)
      data_write(lcg_byte());
    for (int k = 0; k < 4; k++)
      put_op(op_mem, 'h0600 + 32 * k, 0, ref_mem['h0600 + 32 * k]);
    reg_write(ppu_bus_pkg::reg_ctrl, 8'h00);
    reg_write(ppu_bus_pkg::reg_addr, 8'h3F);  // Half an address, then dropped
    put_op(op_read, ppu_bus_pkg::reg_status, 0, 8'h00);
    set_addr(14'h0700);
    data_write(lcg_byte());
    put_op(op_mem, 'h0700, 0, ref_mem['h0700]);
    cur_grp = 3;  // Buffered reads
    set_addr(14'h0500);
    data_read();
    set_addr(14'h0600);
    for (int k = 0; k < 4; k++)
      data_read();
    cur_grp = 4;  // Palette, mirrors and grayscale
    set_addr(14'h3F01);
    for (int k = 1; k < 32; k++)
      data_write(lcg_byte());
    set_addr(14'h3F01);
    for (int k = 1; k < 32; k++)
      data_read();
    reg_write(ppu_bus_pkg::reg_mask, 8'h01);
    set_addr(14'h3F01);
    for (int k = 0; k < 4; k++)
      data_read();
    reg_write(ppu_bus_pkg::reg_mask, 8'h00);
    cur_grp = 5;  // Vblank and NMI
    reg_write(ppu_bus_pkg::reg_ctrl, 8'h80);
    put_op(op_nmi, 0, 0, 0);
    put_op(op_wait_vbl, 0, 0, 0);
    put_op(op_read, ppu_bus_pkg::reg_status, 0, 8'h80);
    put_op(op_nmi, 0, 0, 0);
    put_op(op_read, ppu_bus_pkg::reg_status, 0, 8'h00);
    cur_grp = 6;  // Solid background through palette entry 3
    set_addr(14'h3F03);
    data_write(8'h2A);
    reg_write(ppu_bus_pkg::reg_mask, 8'h0A);
    put_op(op_color, 0, 0, {2'b00, pal_ref[3]});

    repeat (16) @(posedge clk);
    #10;
    reset = 1'b0;
    check_bit("nmi", nmi, 1'b0);
    check_bit("vram_w", vram_w, 1'b0);
    check_bit("vram_r", vram_r, 1'b0);
    err_mark = 0;
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
      if (i == n_ops - 1 || op_grp[i + 1] != op_grp[i]) begin
        $display("test %0d done, %0d errors", op_grp[i], n_errors - err_mark);
        err_mark = n_errors;
      end
    end
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- sim.f
ppu_timing_pkg.sv
ppu_bus_pkg.sv
ppu_frame_timer.sv
ppu_scroll_regs.sv
ppu_bg_painter.sv
ppu_palette_ram.sv
ppu_cpu_port.sv
ppu_top.sv
tb_ppu.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module ppu_top -f sim.f

sim:
	verilator --binary --timing --top-module tb_ppu -f sim.f -o tb_ppu
	./obj_dir/tb_ppu | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
